/* hw/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// ====================
	// CPU write width
	// ====================
	typedef enum logic [1:0] {
		SIZE_BYTE,
		SIZE_HALF,
		SIZE_WORD
	} access_size_t;

	// ====================
	// Miss handling FSM
	// ====================
	typedef enum logic [2:0] {
		READY,
		FILL_REQUEST,
		FILL_WAIT,
		WRITEBACK_REQUEST,
		WRITEBACK_WAIT
	} cache_state_t;

endpackage

`default_nettype wire

/* hw/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
	parameter LINE_SIZE = 256,
	parameter ADDR_SIZE = 12
) (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  logic                   cpu_valid,
	input  logic                   cpu_write,
	input  logic                   hit,
	input  logic                   victim_dirty,
	input  logic [ADDR_SIZE-1:0]   victim_addr,
	input  logic [ADDR_SIZE-1:0]   cpu_line_addr,
	input  logic [LINE_SIZE-1:0]   line_data,
	input  logic                   mem_ready,
	output logic                   cpu_ready,
	output logic                   mem_valid,
	output logic                   mem_write,
	output logic [ADDR_SIZE-1:0]   mem_addr,
	output logic [LINE_SIZE-1:0]   mem_wr_data,
	output logic                   tag_we,
	output logic                   tag_set_dirty,
	output logic                   tag_clean,
	output logic                   tag_fill,
	output logic                   data_merge,
	output logic                   data_fill
);

	cache_pkg::cache_state_t state;
	cache_pkg::cache_state_t next_state;

	// ====================
	// Next state
	// ====================
	always_comb begin
		next_state = state;
		case (state)
			cache_pkg::READY: begin
				if (cpu_valid && !hit && mem_ready) begin
					if (victim_dirty)
						next_state = cache_pkg::WRITEBACK_REQUEST;
					else
						next_state = cache_pkg::FILL_REQUEST;
				end
			end
			cache_pkg::FILL_REQUEST:      next_state = cache_pkg::FILL_WAIT; // One cycle pulse
			cache_pkg::FILL_WAIT: begin
				if (mem_ready)
					next_state = cache_pkg::READY;
			end
			cache_pkg::WRITEBACK_REQUEST: next_state = cache_pkg::WRITEBACK_WAIT;
			cache_pkg::WRITEBACK_WAIT: begin
				if (mem_ready)
					next_state = cache_pkg::FILL_REQUEST; // Refill once the victim is written
			end
			default:                      next_state = cache_pkg::READY;
		endcase
	end

	// ====================
	// Outputs
	// ====================
	always_comb begin
		cpu_ready     = 1'b0;
		mem_valid     = 1'b0;
		mem_write     = 1'b0;
		mem_addr      = '0;
		mem_wr_data   = '0;
		tag_we        = 1'b0;
		tag_set_dirty = 1'b0;
		tag_clean     = 1'b0;
		tag_fill      = 1'b0;
		data_merge    = 1'b0;
		data_fill     = 1'b0;
		case (state)
			cache_pkg::READY: begin
				cpu_ready     = 1'b1;
				data_merge    = cpu_valid && cpu_write && hit; // Write hit
				tag_we        = cpu_valid && cpu_write && hit;
				tag_set_dirty = 1'b1;
			end
			cache_pkg::FILL_REQUEST: begin
				mem_valid = 1'b1;
				mem_addr  = cpu_line_addr;
			end
			cache_pkg::FILL_WAIT: begin
				cpu_ready     = mem_ready;
				mem_addr      = cpu_line_addr;
				data_fill     = mem_ready;
				tag_we        = mem_ready;
				tag_fill      = 1'b1;
				tag_set_dirty = cpu_write; // Write-allocate leaves line dirty
			end
			cache_pkg::WRITEBACK_REQUEST: begin
				mem_valid   = 1'b1;
				mem_write   = 1'b1;
				mem_addr    = victim_addr;
				mem_wr_data = line_data;
			end
			cache_pkg::WRITEBACK_WAIT: begin
				mem_write   = 1'b1;
				mem_addr    = victim_addr;
				mem_wr_data = line_data;
				tag_we      = mem_ready;
				tag_clean   = 1'b1;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			state <= cache_pkg::READY;
		else
			state <= next_state;
	end

	// Memory goes busy after every request
	assert property (@(posedge clk_i) disable iff (reset_i)
		mem_valid |=> !mem_ready);

	// Fill never replaces a dirty line
	assert property (@(posedge clk_i) disable iff (reset_i)
		(mem_valid && !mem_write) |-> !victim_dirty);

endmodule

`default_nettype wire

/* hw/tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_store #(
	parameter SIZE      = 2048,
	parameter LINE_SIZE = 256,
	parameter ADDR_SIZE = 12,
	parameter WORD_SIZE = 32
) (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic [ADDR_SIZE-1:0] cpu_addr,
	input  logic                 tag_we,
	input  logic                 tag_set_dirty,
	input  logic                 tag_clean,
	input  logic                 tag_fill,
	output logic                 hit,
	output logic                 victim_dirty,
	output logic [ADDR_SIZE-1:0] victim_addr
);

	localparam NUM_LINES      = SIZE / LINE_SIZE;
	localparam WORDS_PER_LINE = LINE_SIZE / WORD_SIZE;
	localparam INDEX_BITS     = $clog2(NUM_LINES);
	localparam WORD_BITS      = $clog2(WORDS_PER_LINE);
	localparam WOFF_BITS      = $clog2(WORD_SIZE / 8);
	localparam OFFSET_BITS    = WORD_BITS + WOFF_BITS;
	localparam TAG_BITS       = ADDR_SIZE - INDEX_BITS - OFFSET_BITS;

	logic [NUM_LINES-1:0] valid;
	logic [NUM_LINES-1:0] dirty;
	logic [TAG_BITS-1:0]  tags [NUM_LINES];

	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0]   addr_tag;

	assign index    = cpu_addr[OFFSET_BITS +: INDEX_BITS];
	assign addr_tag = cpu_addr[ADDR_SIZE-1 -: TAG_BITS];

	assign hit          = valid[index] && (tags[index] == addr_tag);
	assign victim_dirty = valid[index] && dirty[index];
	assign victim_addr  = {tags[index], index, {OFFSET_BITS{1'b0}}}; // Line aligned

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			valid <= '0;
			dirty <= '0;
			for (int i = 0; i < NUM_LINES; i++)
				tags[i] <= '0;
		end else if (tag_we) begin
			if (tag_fill) begin
				tags[index]  <= addr_tag;
				valid[index] <= 1'b1;
				dirty[index] <= tag_set_dirty;
			end else if (tag_clean) begin
				dirty[index] <= 1'b0; // After writeback
			end else if (tag_set_dirty) begin
				dirty[index] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module data_store #(
	parameter SIZE      = 2048,
	parameter LINE_SIZE = 256,
	parameter ADDR_SIZE = 12,
	parameter WORD_SIZE = 32
) (
	input  logic                    clk_i,
	input  logic                    reset_i,
	input  logic [ADDR_SIZE-1:0]    cpu_addr,
	input  logic                    cpu_write,
	input  cache_pkg::access_size_t cpu_size,
	input  logic [WORD_SIZE-1:0]    cpu_wr_data,
	input  logic                    data_merge,
	input  logic                    data_fill,
	input  logic [LINE_SIZE-1:0]    mem_rd_data,
	output logic [WORD_SIZE-1:0]    cpu_rd_data,
	output logic [LINE_SIZE-1:0]    line_data
);

	localparam NUM_LINES      = SIZE / LINE_SIZE;
	localparam WORDS_PER_LINE = LINE_SIZE / WORD_SIZE;
	localparam INDEX_BITS     = $clog2(NUM_LINES);
	localparam WORD_BITS      = $clog2(WORDS_PER_LINE);
	localparam WOFF_BITS      = $clog2(WORD_SIZE / 8);
	localparam OFFSET_BITS    = WORD_BITS + WOFF_BITS;

	logic [WORDS_PER_LINE-1:0][WORD_SIZE-1:0] lines [NUM_LINES];
	logic [WORDS_PER_LINE-1:0][WORD_SIZE-1:0] cur_line;
	logic [WORDS_PER_LINE-1:0][WORD_SIZE-1:0] next_line;

	logic [INDEX_BITS-1:0] index;
	logic [WORD_BITS-1:0]  word;
	logic [WOFF_BITS-1:0]  woff;

	assign index = cpu_addr[OFFSET_BITS +: INDEX_BITS];
	assign word  = cpu_addr[WOFF_BITS +: WORD_BITS];
	assign woff  = cpu_addr[WOFF_BITS-1:0];

	assign cur_line  = lines[index];
	assign line_data = cur_line; // Victim line for writeback

	// Incoming line on fill, then the sized CPU write on top
	always_comb begin
		next_line = data_fill ? mem_rd_data : cur_line;
		if (cpu_write) begin
			case (cpu_size)
				cache_pkg::SIZE_BYTE: next_line[word][8 * woff +: 8]  = cpu_wr_data[7:0];
				cache_pkg::SIZE_HALF: next_line[word][8 * woff +: 16] = cpu_wr_data[15:0];
				cache_pkg::SIZE_WORD: next_line[word]                 = cpu_wr_data;
				default: begin
				end
			endcase
		end
	end

	assign cpu_rd_data = data_fill ? next_line[word] : cur_line[word];

	always_ff @(posedge clk_i) begin
		if (data_merge || data_fill)
			lines[index] <= next_line;
	end

	assert property (@(posedge clk_i) disable iff (reset_i)
		((data_merge || data_fill) && cpu_write) |->
			(cpu_size == cache_pkg::SIZE_BYTE || cpu_size == cache_pkg::SIZE_HALF ||
			cpu_size == cache_pkg::SIZE_WORD));

endmodule

`default_nettype wire

/* hw/line_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module line_memory #(
	parameter LINE_SIZE   = 256,
	parameter ADDR_SIZE   = 12,
	parameter MEM_LATENCY = 3
) (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 mem_valid,
	input  logic                 mem_write,
	input  logic [ADDR_SIZE-1:0] mem_addr,
	input  logic [LINE_SIZE-1:0] mem_wr_data,
	output logic                 mem_ready,
	output logic [LINE_SIZE-1:0] mem_rd_data
);

	localparam OFFSET_BITS = $clog2(LINE_SIZE / 8);
	localparam LINE_BITS   = ADDR_SIZE - OFFSET_BITS;
	localparam MEM_LINES   = 2 ** LINE_BITS;
	localparam COUNT_BITS  = $clog2(MEM_LATENCY + 1);

	logic [LINE_SIZE-1:0]  store [MEM_LINES];
	logic [LINE_BITS-1:0]  line_index;
	logic [LINE_BITS-1:0]  pending_index;
	logic [COUNT_BITS-1:0] count;
	logic                  accept;
	logic                  done;

	assign line_index = mem_addr[ADDR_SIZE-1:OFFSET_BITS];
	assign accept     = mem_valid && mem_ready;
	assign done       = !mem_ready && (count == COUNT_BITS'(1)); // Last busy cycle

	// ====================
	// Latency countdown
	// ====================
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			mem_ready <= 1'b1;
			count     <= '0;
			for (int i = 0; i < MEM_LINES; i++)
				store[i] <= '0;
		end else if (accept) begin
			mem_ready <= 1'b0;
			count     <= COUNT_BITS'(MEM_LATENCY);
			if (mem_write)
				store[line_index] <= mem_wr_data; // Written at accept
		end else if (!mem_ready) begin
			count <= count - 1'b1;
			if (done)
				mem_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept)
			pending_index <= line_index;
		if (done)
			mem_rd_data <= store[pending_index]; // Held while idle
	end

	assert property (@(posedge clk_i) disable iff (reset_i)
		mem_valid |-> mem_ready);

endmodule

`default_nettype wire

/* hw/cache_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem #(
	parameter SIZE        = 2048,
	parameter LINE_SIZE   = 256,
	parameter ADDR_SIZE   = 12,
	parameter WORD_SIZE   = 32,
	parameter MEM_LATENCY = 3
) (
	input  logic                    clk_i,
	input  logic                    reset_i,
	input  logic                    cpu_valid,
	input  logic                    cpu_write,
	input  cache_pkg::access_size_t cpu_size,
	input  logic [ADDR_SIZE-1:0]    cpu_addr,
	input  logic [WORD_SIZE-1:0]    cpu_wr_data,
	output logic                    cpu_ready,
	output logic [WORD_SIZE-1:0]    cpu_rd_data,
	output logic                    cpu_miss
);

	localparam OFFSET_BITS = $clog2(LINE_SIZE / 8);

	logic                 hit;
	logic                 victim_dirty;
	logic [ADDR_SIZE-1:0] victim_addr;
	logic [ADDR_SIZE-1:0] cpu_line_addr;
	logic [LINE_SIZE-1:0] line_data;
	logic                 tag_we;
	logic                 tag_set_dirty;
	logic                 tag_clean;
	logic                 tag_fill;
	logic                 data_merge;
	logic                 data_fill;

	// Memory side
	logic                 mem_valid;
	logic                 mem_write;
	logic [ADDR_SIZE-1:0] mem_addr;
	logic [LINE_SIZE-1:0] mem_wr_data;
	logic                 mem_ready;
	logic [LINE_SIZE-1:0] mem_rd_data;

	assign cpu_line_addr = {cpu_addr[ADDR_SIZE-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign cpu_miss      = !hit;

	cache_ctrl #(.LINE_SIZE(LINE_SIZE), .ADDR_SIZE(ADDR_SIZE)) cache_ctrl_inst (
		.clk_i, .reset_i, .cpu_valid, .cpu_write, .hit, .victim_dirty, .victim_addr,
		.cpu_line_addr, .line_data, .mem_ready, .cpu_ready, .mem_valid, .mem_write,
		.mem_addr, .mem_wr_data, .tag_we, .tag_set_dirty, .tag_clean, .tag_fill,
		.data_merge, .data_fill
	);

	tag_store #(.SIZE(SIZE), .LINE_SIZE(LINE_SIZE), .ADDR_SIZE(ADDR_SIZE),
		.WORD_SIZE(WORD_SIZE)) tag_store_inst (
		.clk_i, .reset_i, .cpu_addr, .tag_we, .tag_set_dirty, .tag_clean, .tag_fill,
		.hit, .victim_dirty, .victim_addr
	);

	data_store #(.SIZE(SIZE), .LINE_SIZE(LINE_SIZE), .ADDR_SIZE(ADDR_SIZE),
		.WORD_SIZE(WORD_SIZE)) data_store_inst (
		.clk_i, .reset_i, .cpu_addr, .cpu_write, .cpu_size, .cpu_wr_data, .data_merge,
		.data_fill, .mem_rd_data, .cpu_rd_data, .line_data
	);

	line_memory #(.LINE_SIZE(LINE_SIZE), .ADDR_SIZE(ADDR_SIZE),
		.MEM_LATENCY(MEM_LATENCY)) line_memory_inst (
		.clk_i, .reset_i, .mem_valid, .mem_write, .mem_addr, .mem_wr_data, .mem_ready,
		.mem_rd_data
	);

endmodule

`default_nettype wire

/* test/cache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_checker #(
	parameter ADDR_SIZE = 12,
	parameter WORD_SIZE = 32
) (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 cpu_valid,
	input  logic                 cpu_write,
	input  logic [ADDR_SIZE-1:0] cpu_addr,
	input  logic                 cpu_ready,
	input  logic [WORD_SIZE-1:0] cpu_rd_data,
	input  logic                 cpu_miss,
	input  logic [WORD_SIZE-1:0] exp_rd_data,
	input  logic                 exp_miss,
	input  int                   test_num,
	input  logic                 run_done,
	output int                   error_count
);

	logic active; // Miss in progress
	logic seen_low;
	logic reported;
	int   cur_test;
	int   test_errors;
	int   test_accesses;

	task automatic report_test();
		if (test_errors == 0)
			$display("test %0d: %0d accesses, passed", cur_test, test_accesses);
		else
			$display("test %0d: %0d accesses, %0d errors, failed", cur_test, test_accesses,
				test_errors);
	endtask

	// Writes are counted and reads checked on the completing edge
	task automatic complete_access();
		test_accesses++;
		if (!cpu_write && cpu_rd_data !== exp_rd_data) begin
			$display("mismatch at %0t: test %0d read of %h gave %h, expected %h", $time,
				cur_test, cpu_addr, cpu_rd_data, exp_rd_data);
			error_count++;
			test_errors++;
		end
		active = 1'b0;
	endtask

	always @(posedge clk_i) begin
		if (reset_i) begin
			active        = 1'b0;
			seen_low      = 1'b0;
			reported      = 1'b0;
			cur_test      = 0;
			test_errors   = 0;
			test_accesses = 0;
			error_count   = 0;
		end else if (run_done) begin
			if (!reported && cur_test != 0)
				report_test();
			reported = 1'b1;
		end else if (cpu_valid && !active) begin
			if (test_num != cur_test) begin
				if (cur_test != 0)
					report_test();
				cur_test      = test_num;
				test_errors   = 0;
				test_accesses = 0;
			end
			if (cpu_miss !== exp_miss) begin
				$display("mismatch at %0t: test %0d access to %h miss %b, expected %b", $time,
					cur_test, cpu_addr, cpu_miss, exp_miss);
				error_count++;
				test_errors++;
			end
			// A hit must finish in its first cycle
			if (!exp_miss && cpu_ready !== 1'b1) begin
				$display("mismatch at %0t: test %0d hit on %h without cpu_ready", $time,
					cur_test, cpu_addr);
				error_count++;
				test_errors++;
			end
			seen_low = 1'b0;
			active   = 1'b1;
			if (cpu_ready && !cpu_miss)
				complete_access(); // Hit with zero wait
		end else if (active) begin
			if (!cpu_ready)
				seen_low = 1'b1;
			else if (seen_low)
				complete_access();
		end
	end

endmodule

`default_nettype wire

/* test/tb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

	localparam SIZE        = 2048;
	localparam LINE_SIZE   = 256;
	localparam ADDR_SIZE   = 12;
	localparam WORD_SIZE   = 32;
	localparam MEM_LATENCY = 3;
	localparam MAX_WAIT    = 50; // Cycles per access

	logic                    clk_i;
	logic                    reset_i;
	logic                    cpu_valid;
	logic                    cpu_write;
	cache_pkg::access_size_t cpu_size;
	logic [ADDR_SIZE-1:0]    cpu_addr;
	logic [WORD_SIZE-1:0]    cpu_wr_data;
	logic                    cpu_ready;
	logic [WORD_SIZE-1:0]    cpu_rd_data;
	logic                    cpu_miss;

	// Expected values handed to the checker
	logic [WORD_SIZE-1:0] exp_rd_data;
	logic                 exp_miss;
	int                   test_num;
	logic                 run_done;
	int                   error_count;
	int                   accesses;
	int                   failures;

	cache_subsystem #(.SIZE(SIZE), .LINE_SIZE(LINE_SIZE), .ADDR_SIZE(ADDR_SIZE),
		.WORD_SIZE(WORD_SIZE), .MEM_LATENCY(MEM_LATENCY)) cache_subsystem_inst (
		.clk_i, .reset_i, .cpu_valid, .cpu_write, .cpu_size, .cpu_addr, .cpu_wr_data,
		.cpu_ready, .cpu_rd_data, .cpu_miss
	);

	cache_checker #(.ADDR_SIZE(ADDR_SIZE), .WORD_SIZE(WORD_SIZE)) cache_checker_inst (
		.clk_i, .reset_i, .cpu_valid, .cpu_write, .cpu_addr, .cpu_ready, .cpu_rd_data,
		.cpu_miss, .exp_rd_data, .exp_miss, .test_num, .run_done, .error_count
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// ====================
	// One CPU access
	// ====================
	// A miss shows cpu_ready high in its first cycle, so completion is the
	// next cpu_ready after it has dropped
	task automatic run_access(input int write, input int size, input logic [31:0] addr,
		input logic [31:0] wdata, output logic timed_out);
		int   cycles;
		logic first_miss;
		logic seen_low;
		logic done;
		cpu_valid   = 1'b1;
		cpu_write   = write[0];
		cpu_size    = cache_pkg::access_size_t'(size[1:0]);
		cpu_addr    = addr[ADDR_SIZE-1:0];
		cpu_wr_data = wdata;
		cycles      = 0;
		first_miss  = 1'b0;
		seen_low    = 1'b0;
		done        = 1'b0;
		while (!done && cycles < MAX_WAIT) begin
			@(posedge clk_i);
			cycles++;
			if (cycles == 1)
				first_miss = cpu_miss;
			if (!cpu_ready)
				seen_low = 1'b1;
			else if (!first_miss || seen_low)
				done = 1'b1;
		end
		#1;
		timed_out = !done;
		if (!done)
			$display("timeout waiting for cpu_ready in test %0d, address %h", test_num, addr);
	endtask

	initial begin
		int          fd;
		int          code;
		int          row_test;
		int          row_write;
		int          row_size;
		int          row_miss;
		logic [31:0] row_addr;
		logic [31:0] row_wdata;
		logic [31:0] row_rdata;
		logic        timed_out;
		reset_i     = 1'b1;
		cpu_valid   = 1'b0;
		cpu_write   = 1'b0;
		cpu_size    = cache_pkg::SIZE_WORD;
		cpu_addr    = '0;
		cpu_wr_data = '0;
		exp_rd_data = '0;
		exp_miss    = 1'b0;
		test_num    = 0;
		run_done    = 1'b0;
		accesses    = 0;
		failures    = 0;
		timed_out   = 1'b0;
		repeat (4) @(posedge clk_i);
		#1 reset_i = 1'b0;

		fd = $fopen("test/cache_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open test/cache_stim.txt");
			failures++;
		end else begin
			code = $fscanf(fd, "%d %d %d %h %h %h %d\n", row_test, row_write, row_size,
				row_addr, row_wdata, row_rdata, row_miss);
			while (code == 7 && !timed_out) begin
				test_num    = row_test;
				exp_rd_data = row_rdata;
				exp_miss    = row_miss[0];
				run_access(row_write, row_size, row_addr, row_wdata, timed_out);
				accesses++;
				if (timed_out)
					failures++;
				code = $fscanf(fd, "%d %d %d %h %h %h %d\n", row_test, row_write, row_size,
					row_addr, row_wdata, row_rdata, row_miss);
			end
			$fclose(fd);
		end

		cpu_valid = 1'b0;
		run_done  = 1'b1; // Checker closes the last test
		repeat (2) @(posedge clk_i);
		$display("%0d accesses, %0d mismatches, %0d other failures", accesses, error_count,
			failures);
		if (error_count == 0 && failures == 0 && accesses > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* test/cache_stim.txt */
1 0 2 000 00000000 00000000 1
1 0 2 004 00000000 00000000 0
1 0 2 01c 00000000 00000000 0
2 1 0 005 000000ab 00000000 0
2 0 2 004 00000000 0000ab00 0
2 1 1 006 00001234 00000000 0
2 0 2 004 00000000 1234ab00 0
2 1 2 008 deadbeef 00000000 0
2 0 2 008 00000000 deadbeef 0
2 1 0 00b 0000005a 00000000 0
2 0 2 008 00000000 5aadbeef 0
3 1 2 124 11223344 00000000 1
3 0 2 124 00000000 11223344 0
3 0 2 120 00000000 00000000 0
4 0 2 200 00000000 00000000 1
4 0 2 004 00000000 1234ab00 1
4 0 2 008 00000000 5aadbeef 0
4 0 2 324 00000000 00000000 1
4 0 2 124 00000000 11223344 1
5 0 2 044 00000000 00000000 1
5 0 2 544 00000000 00000000 1
5 0 2 044 00000000 00000000 1
5 0 2 200 00000000 00000000 1
5 0 2 008 00000000 5aadbeef 1
6 1 2 a60 a0a0a0a0 00000000 1
6 0 2 b60 00000000 00000000 1
6 0 2 a60 00000000 a0a0a0a0 1
6 1 1 b62 0000beef 00000000 1
6 0 2 a60 00000000 a0a0a0a0 1
6 0 2 b60 00000000 beef0000 1
6 1 0 a61 00000055 00000000 1
6 0 2 b60 00000000 beef0000 1
6 1 2 a64 0badf00d 00000000 1
6 1 0 b60 00000011 00000000 1
6 0 2 a64 00000000 0badf00d 1
6 0 2 b60 00000000 beef0011 1

/* list.f */
hw/cache_pkg.sv
hw/cache_ctrl.sv
hw/tag_store.sv
hw/data_store.sv
hw/line_memory.sv
hw/cache_subsystem.sv
test/cache_checker.sv
test/tb_cache.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -f list.f -o tb_cache \
	> build.log 2>&1 \
	&& ./obj_dir/tb_cache > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
